//--- verilog/sha512_pad_pkg.sv
// Block geometry and shared types for the SHA-512 message padding front end
// Imported by the block buffer and the padding FSM
package sha512_pad_pkg;

  // ----------------------------------------------------------------------
  // Block geometry
  // ----------------------------------------------------------------------

  // Message words arrive 32 bits wide, most significant byte first
  localparam int word_w = 32;
  localparam int block_w = 1024;
  localparam int block_dwords = block_w / word_w;
  localparam int block_bytes = block_w / 8;

  // The bit length of the message sits in the low 128 bits of the final block
  localparam int len_field_bytes = 16;

  // Largest tail that still leaves room for the 0x80 byte and the length field
  localparam int pad_limit = block_bytes - len_field_bytes - 1;

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------

  // The block register is filled a dword at a time and padded a byte at a time
  // Entry 0 of either view is the most significant part of the block
  typedef union packed {
    logic [0:block_dwords-1][word_w-1:0] dwords;
    logic [0:block_bytes-1][7:0] bytes;
  } sha_block_u;

  // Padding sequencer states
  // pad0 holds a tail with its 0x80 byte, a zeros-and-length block follows
  // pad1 holds a full data block that ends the message, a pad block follows
  // flush holds the final block of the message
  typedef enum logic [2:0] {
    idle,
    block,
    pad0,
    pad1,
    flush
  } pad_state_e;

endpackage

//--- verilog/msg_block_buffer.sv
// Message block register for the SHA-512 padding front end
// Packs message words into a 1024-bit block and writes the padding patterns
// on command from pad_fsm
`timescale 1ns/1ps

module msg_block_buffer #(
  parameter int max_len_w = 32
) (
  input  logic                              clk,
  input  logic                              rst_b,
  input  logic [sha512_pad_pkg::word_w-1:0] msg_data,
  input  logic [max_len_w-1:0]              msg_len,
  input  logic                              word_accept,
  input  logic                              apply_pad,
  input  logic                              load_len_block,
  input  logic                              block_clear,
  output sha512_pad_pkg::sha_block_u        block,
  output logic                              block_full,
  output logic                              msg_done,
  output logic                              needs_extra,
  output logic                              tail_empty
);

  import sha512_pad_pkg::*;

  // One extra pointer bit marks a full block
  localparam int ptr_w = $clog2(block_dwords) + 1;
  localparam int tail_w = $clog2(block_bytes);
  // The byte count may run up to three bytes past the length
  localparam int cnt_w = max_len_w + 1;
  localparam int len_field_w = 8 * len_field_bytes;
  localparam int len_lsb = block_bytes - len_field_bytes;

  logic                   in_msg;
  logic                   first_word;
  logic [max_len_w-1:0]   len_q;
  logic [max_len_w-1:0]   len_use;
  logic [cnt_w-1:0]       byte_cnt;
  logic [cnt_w-1:0]       cnt_use;
  logic [cnt_w-1:0]       cnt_nxt;
  logic [ptr_w-1:0]       wptr;
  logic [tail_w-1:0]      tail_bytes;
  logic [len_field_w-1:0] len_bits;
  logic [block_w-1:0]     pad_mask;
  sha_block_u             block_wr;
  sha_block_u             block_nxt;

  // ----------------------------------------------------------------------
  // Length and byte accounting
  // ----------------------------------------------------------------------

  // A word taken outside a message opens a new one and carries its length
  assign first_word = word_accept & ~in_msg;

  // The first word is judged against the length at the port, later ones
  // and all padding commands against the latched length
  assign len_use = first_word ? msg_len : len_q;
  assign cnt_use = first_word ? '0 : byte_cnt;
  assign cnt_nxt = cnt_use + cnt_w'(word_w / 8);

  // High when the word at the input brings the byte count up to the length
  assign msg_done = cnt_nxt >= {1'b0, len_use};

  // Bytes of message data that land in the final data block
  assign tail_bytes = len_use[tail_w-1:0];
  assign needs_extra = tail_bytes > tail_w'(pad_limit);
  assign tail_empty = tail_bytes == '0;

  assign block_full = wptr[ptr_w-1];

  // SHA-512 appends the length in bits as a 128-bit big-endian number
  assign len_bits = len_field_w'(len_use) << 3;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      in_msg <= 1'b0;
      len_q <= '0;
      byte_cnt <= '0;
      wptr <= '0;
    end else begin
      if (word_accept) begin
        // The message stays open until its last word is taken
        in_msg <= ~msg_done;
        byte_cnt <= cnt_nxt;
      end
      if (first_word) begin
        len_q <= msg_len;
      end
      // A taken block restarts assembly at dword 0
      if (block_clear) begin
        wptr <= '0;
      end else if (word_accept) begin
        wptr <= wptr + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Block assembly and padding
  // ----------------------------------------------------------------------

  always_comb begin
    block_wr = block;
    if (word_accept) begin
      block_wr.dwords[wptr[ptr_w-2:0]] = msg_data;
    end

    // Ones over the valid tail bytes, zeros over everything after them
    pad_mask = ~({block_w{1'b1}} >> (8 * tail_bytes));

    block_nxt = block_wr;
    if (load_len_block) begin
      // Extra block after a long tail holds only zeros and the length
      block_nxt = '0;
      block_nxt.bytes[len_lsb +: len_field_bytes] = len_bits;
    end else if (apply_pad) begin
      // The last word is written and padded in the same cycle
      block_nxt = block_wr & pad_mask;
      block_nxt.bytes[tail_bytes] = 8'h80;
      // A long tail leaves no room, the length goes into the extra block
      if (!needs_extra) begin
        block_nxt.bytes[len_lsb +: len_field_bytes] = len_bits;
      end
    end
  end

  always_ff @(posedge clk) begin
    block <= block_nxt;
  end

  // The FSM withholds words while a full block waits for the consumer
  assert property (@(posedge clk) disable iff (!rst_b) word_accept |-> !block_full)
    else $error("message word written into a full block");

  // The length block only replaces a block that is being taken
  assert property (@(posedge clk) disable iff (!rst_b) load_len_block |-> block_clear)
    else $error("length block loaded over a block that was not taken");

endmodule

//--- verilog/pad_fsm.sv
// Padding sequencer for the SHA-512 front end
// Steps a message through its data blocks and pad blocks, drives the block
// handshake and issues the buffer commands
`timescale 1ns/1ps

module pad_fsm #(
  parameter int max_len_w = 32
) (
  input  logic clk,
  input  logic rst_b,
  input  logic msg_valid,
  input  logic blk_ready,
  input  logic block_full,
  input  logic msg_done,
  input  logic needs_extra,
  input  logic tail_empty,
  output logic msg_ready,
  output logic blk_valid,
  output logic blk_first,
  output logic blk_last,
  output logic word_accept,
  output logic apply_pad,
  output logic load_len_block,
  output logic block_clear
);

  import sha512_pad_pkg::*;

  // Enough bits to count every block of the longest message
  localparam int cnt_w = max_len_w - $clog2(block_bytes) + 1;

  pad_state_e       state_q;
  pad_state_e       state_d;
  pad_state_e       tail_state;
  logic [cnt_w-1:0] blk_cnt;
  logic             take;
  logic             last_word;

  // ----------------------------------------------------------------------
  // Handshakes and buffer commands
  // ----------------------------------------------------------------------

  // Words flow only while no block waits for the consumer
  assign msg_ready = (state_q == idle) | ((state_q == block) & ~block_full);
  assign word_accept = msg_valid & msg_ready;
  assign last_word = word_accept & msg_done;

  assign blk_valid = ((state_q == block) & block_full) | (state_q == pad0) |
                     (state_q == pad1) | (state_q == flush);
  assign blk_last = state_q == flush;
  // First block of a message goes to the hash core as INIT
  assign blk_first = blk_valid & (blk_cnt == '0);
  assign take = blk_valid & blk_ready;
  assign block_clear = take;

  // A tail is padded together with its last word
  // A boundary message gets its pad block once the data block is taken
  assign apply_pad = (last_word & ~tail_empty) | ((state_q == pad1) & take);
  assign load_len_block = (state_q == pad0) & take;

  // Where the message goes after its last word
  assign tail_state = tail_empty ? pad1 : (needs_extra ? pad0 : flush);

  // ----------------------------------------------------------------------
  // State register and block count
  // ----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      idle: begin
        if (word_accept) begin
          state_d = msg_done ? tail_state : block;
        end
      end
      block: begin
        if (last_word) begin
          state_d = tail_state;
        end
      end
      pad0, pad1: begin
        if (take) begin
          state_d = flush;
        end
      end
      flush: begin
        if (take) begin
          state_d = idle;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q <= idle;
      blk_cnt <= '0;
    end else begin
      state_q <= state_d;
      // Counts blocks of the current message, restarts after the final one
      if (take) begin
        blk_cnt <= blk_last ? '0 : blk_cnt + 1'b1;
      end
    end
  end

  // A waiting block keeps its valid and flags until the consumer takes it
  assert property (@(posedge clk) disable iff (!rst_b)
    blk_valid && !blk_ready |=> blk_valid && $stable(blk_first) && $stable(blk_last))
    else $error("block output dropped or changed before it was taken");

endmodule

//--- verilog/sha512_pad_top.sv
// Top level of the SHA-512 message padding front end
// Takes 32-bit big-endian message words and hands out padded 1024-bit blocks
// flagged first and last for a hash core
`timescale 1ns/1ps

module sha512_pad_top #(
  parameter int max_len_w = 32
) (
  input  logic                               clk,
  input  logic                               rst_b,
  // Message word stream, length sampled with the first word
  input  logic                               msg_valid,
  output logic                               msg_ready,
  input  logic [sha512_pad_pkg::word_w-1:0]  msg_data,
  input  logic [max_len_w-1:0]               msg_len,
  // Padded block stream
  output logic                               blk_valid,
  input  logic                               blk_ready,
  output logic [sha512_pad_pkg::block_w-1:0] blk_data,
  output logic                               blk_first,
  output logic                               blk_last
);

  // Commands from the sequencer to the buffer
  logic word_accept;
  logic apply_pad;
  logic load_len_block;
  logic block_clear;

  // Status from the buffer to the sequencer
  logic block_full;
  logic msg_done;
  logic needs_extra;
  logic tail_empty;

  // The block register drives the output data directly
  msg_block_buffer #(
    .max_len_w(max_len_w)
  ) msg_block_buffer_inst (
    .clk           (clk),
    .rst_b         (rst_b),
    .msg_data      (msg_data),
    .msg_len       (msg_len),
    .word_accept   (word_accept),
    .apply_pad     (apply_pad),
    .load_len_block(load_len_block),
    .block_clear   (block_clear),
    .block         (blk_data),
    .block_full    (block_full),
    .msg_done      (msg_done),
    .needs_extra   (needs_extra),
    .tail_empty    (tail_empty)
  );

  pad_fsm #(
    .max_len_w(max_len_w)
  ) pad_fsm_inst (
    .clk           (clk),
    .rst_b         (rst_b),
    .msg_valid     (msg_valid),
    .blk_ready     (blk_ready),
    .block_full    (block_full),
    .msg_done      (msg_done),
    .needs_extra   (needs_extra),
    .tail_empty    (tail_empty),
    .msg_ready     (msg_ready),
    .blk_valid     (blk_valid),
    .blk_first     (blk_first),
    .blk_last      (blk_last),
    .word_accept   (word_accept),
    .apply_pad     (apply_pad),
    .load_len_block(load_len_block),
    .block_clear   (block_clear)
  );

endmodule

//--- include/sha512_pad_ref.svh
// Reference model of the padded block stream for one message
// Included inside the testbench module, which compiles after the package
`ifndef SHA512_PAD_REF_SVH
`define SHA512_PAD_REF_SVH

// Number of blocks that a message of len bytes expands into
function automatic int unsigned blocks_in_msg(input int unsigned len);
  return (len + sha512_pad_pkg::len_field_bytes) / sha512_pad_pkg::block_bytes + 1;
endfunction

// Only the final block of a message carries the last flag
function automatic bit is_final_block(input int unsigned len, input int unsigned idx);
  return idx == blocks_in_msg(len) - 1;
endfunction

// Expected block idx of a message, byte 0 in the most significant position
// Message bytes, then 0x80, then zeros, with the bit length in the final block
function automatic logic [sha512_pad_pkg::block_w-1:0] expected_block(
  input logic [7:0]  msg[],
  input int unsigned len,
  input int unsigned idx
);
  logic [0:sha512_pad_pkg::block_bytes-1][7:0] blk;
  logic [8*sha512_pad_pkg::len_field_bytes-1:0] len_bits;
  int unsigned pos;
  int unsigned len_lsb;
  bit          last;

  len_bits = (8 * sha512_pad_pkg::len_field_bytes)'(len) << 3;
  len_lsb = sha512_pad_pkg::block_bytes - sha512_pad_pkg::len_field_bytes;
  last = is_final_block(len, idx);
  for (int b = 0; b < sha512_pad_pkg::block_bytes; b++) begin
    pos = idx * sha512_pad_pkg::block_bytes + b;
    if (pos < len) begin
      blk[b] = msg[pos];
    end else if (pos == len) begin
      blk[b] = 8'h80;
    end else if (last && b >= len_lsb) begin
      // Length field is big-endian across the last 16 bytes
      blk[b] = len_bits[8 * (sha512_pad_pkg::block_bytes - 1 - b) +: 8];
    end else begin
      blk[b] = 8'h00;
    end
  end
  return blk;
endfunction

`endif

//--- testbench/tb_sha512_pad_top.sv
// Testbench for the SHA-512 message padding front end
// Sends messages of several lengths, collects every padded block and checks
// each one against the reference model in the included header
`timescale 1ns/1ps

module tb_sha512_pad_top;

  import sha512_pad_pkg::*;

  typedef logic [7:0] byte_arr_t[];

  localparam int timeout_cycles = 2000;

  logic               clk;
  logic               rst_b;
  logic               msg_valid;
  logic               msg_ready;
  logic [word_w-1:0]  msg_data;
  logic [31:0]        msg_len;
  logic               blk_valid;
  logic               blk_ready;
  logic [block_w-1:0] blk_data;
  logic               blk_first;
  logic               blk_last;

  integer      seed = 32'h7a00_9440;
  int          errors = 0;
  int          checks = 0;
  int unsigned checked = 0;
  string       test_name = "reset";
  byte_arr_t   msg_a;
  byte_arr_t   msg_b;

  // Every block taken by the consumer, in arrival order
  logic [block_w-1:0] got_data[$];
  bit                 got_first[$];
  bit                 got_last[$];

  `include "sha512_pad_ref.svh"

  sha512_pad_top #(
    .max_len_w(32)
  ) sha512_pad_top_inst (
    .clk      (clk),
    .rst_b    (rst_b),
    .msg_valid(msg_valid),
    .msg_ready(msg_ready),
    .msg_data (msg_data),
    .msg_len  (msg_len),
    .blk_valid(blk_valid),
    .blk_ready(blk_ready),
    .blk_data (blk_data),
    .blk_first(blk_first),
    .blk_last (blk_last)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Handshake checks
  // ----------------------------------------------------------------------

  // A stalled block keeps its data and flags until it is taken
  assert property (@(posedge clk) disable iff (!rst_b)
    blk_valid && !blk_ready |=>
      blk_valid && $stable(blk_data) && $stable(blk_first) && $stable(blk_last))
    else begin
      errors++;
      $display("** Error %s: block output changed while the consumer stalled", test_name);
    end

  // No word enters while a block waits
  assert property (@(posedge clk) disable iff (!rst_b) blk_valid |-> !msg_ready)
    else begin
      errors++;
      $display("** Error %s: msg_ready high while a block is valid", test_name);
    end

  // Sampled at the falling edge, where the handshake is settled
  always @(negedge clk) begin
    if (rst_b && blk_valid && blk_ready) begin
      got_data.push_back(blk_data);
      got_first.push_back(blk_first);
      got_last.push_back(blk_last);
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus and checking tasks
  // ----------------------------------------------------------------------

  // Inputs change 2 ns after a rising edge
  task automatic align_drive();
    @(posedge clk);
    #2;
  endtask

  function automatic byte_arr_t make_msg(input int unsigned len);
    byte_arr_t m;
    m = new[len];
    foreach (m[i]) begin
      m[i] = 8'($random(seed));
    end
    return m;
  endfunction

  task automatic send_msg(input byte_arr_t m);
    int unsigned       words;
    int unsigned       wait_cnt;
    logic [word_w-1:0] word;
    words = (m.size() + 3) / 4;
    align_drive();
    for (int unsigned w = 0; w < words; w++) begin
      // Big-endian packing, bytes past the end carry noise
      for (int unsigned k = 0; k < 4; k++) begin
        word[8*(3-k) +: 8] = (4*w + k < m.size()) ? m[4*w + k] : 8'($random(seed));
      end
      msg_valid = 1'b1;
      msg_data = word;
      // Only the first word's length may matter to the DUT
      msg_len = (w == 0) ? m.size() : $random(seed);
      wait_cnt = 0;
      @(negedge clk);
      while (!msg_ready && wait_cnt < timeout_cycles) begin
        wait_cnt++;
        @(negedge clk);
      end
      if (!msg_ready) begin
        errors++;
        $display("** Error %s: msg_ready never rose for word %0d", test_name, w);
        align_drive();
        msg_valid = 1'b0;
        return;
      end
      align_drive();
    end
    msg_valid = 1'b0;
  endtask

  // Holds blk_ready low for a number of cycles once a block is valid
  task automatic stall_block(input int cycles);
    logic [block_w-1:0] held;
    int unsigned        wait_cnt;
    wait_cnt = 0;
    @(negedge clk);
    while (!blk_valid && wait_cnt < timeout_cycles) begin
      wait_cnt++;
      @(negedge clk);
    end
    if (!blk_valid) begin
      errors++;
      $display("** Error %s: no block became valid to stall", test_name);
      align_drive();
      blk_ready = 1'b1;
      return;
    end
    held = blk_data;
    for (int c = 0; c < cycles; c++) begin
      checks += 2;
      assert (!msg_ready) else begin
        errors++;
        $display("** Error %s msg_ready: expected 0, got %0b", test_name, msg_ready);
      end
      assert (blk_data == held) else begin
        errors++;
        $display("** Error %s stalled data: expected %h, got %h", test_name, held, blk_data);
      end
      @(negedge clk);
    end
    align_drive();
    blk_ready = 1'b1;
  endtask

  // Waits for all blocks of a message, then compares each with the model
  task automatic check_msg(input byte_arr_t m);
    int unsigned        len;
    int unsigned        count;
    int unsigned        wait_cnt;
    logic [block_w-1:0] exp_blk;
    len = m.size();
    count = blocks_in_msg(len);
    wait_cnt = 0;
    while (got_data.size() < checked + count && wait_cnt < timeout_cycles) begin
      wait_cnt++;
      @(negedge clk);
    end
    if (got_data.size() < checked + count) begin
      errors++;
      $display("** Error %s: only %0d of %0d blocks arrived", test_name,
               got_data.size() - checked, count);
      return;
    end
    for (int unsigned i = 0; i < count; i++) begin
      exp_blk = expected_block(m, len, i);
      checks += 3;
      assert (got_data[checked + i] == exp_blk) else begin
        errors++;
        $display("** Error %s block %0d data: expected %h, got %h", test_name, i,
                 exp_blk, got_data[checked + i]);
      end
      assert (got_first[checked + i] == (i == 0)) else begin
        errors++;
        $display("** Error %s block %0d blk_first: expected %0b, got %0b", test_name, i,
                 i == 0, got_first[checked + i]);
      end
      assert (got_last[checked + i] == is_final_block(len, i)) else begin
        errors++;
        $display("** Error %s block %0d blk_last: expected %0b, got %0b", test_name, i,
                 is_final_block(len, i), got_last[checked + i]);
      end
    end
    checked += count;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    rst_b = 1'b0;
    msg_valid = 1'b0;
    msg_data = '0;
    msg_len = '0;
    blk_ready = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    rst_b = 1'b1;

    @(negedge clk);
    checks += 2;
    assert (!blk_valid) else begin
      errors++;
      $display("** Error %s blk_valid: expected 0, got %0b", test_name, blk_valid);
    end
    assert (msg_ready) else begin
      errors++;
      $display("** Error %s msg_ready: expected 1, got %0b", test_name, msg_ready);
    end

    // One block holding data, 0x80 and the length
    test_name = "short_37";
    msg_a = make_msg(37);
    send_msg(msg_a);
    check_msg(msg_a);

    // Tail too long for the length field, an extra block follows
    test_name = "long_tail_120";
    msg_a = make_msg(120);
    send_msg(msg_a);
    check_msg(msg_a);

    // Ends on a block boundary, the pad block starts with 0x80
    test_name = "boundary_256";
    msg_a = make_msg(256);
    send_msg(msg_a);
    check_msg(msg_a);

    test_name = "backpressure_200";
    msg_a = make_msg(200);
    align_drive();
    blk_ready = 1'b0;
    fork
      send_msg(msg_a);
      stall_block(10);
    join
    check_msg(msg_a);

    // The second message starts as soon as the first one's last block leaves
    test_name = "back_to_back_300";
    msg_a = make_msg(150);
    msg_b = make_msg(300);
    send_msg(msg_a);
    send_msg(msg_b);
    check_msg(msg_a);
    check_msg(msg_b);

    $display("Blocks checked: %0d, checks: %0d, errors: %0d", checked, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- sha512_pad_top.f
+incdir+include
verilog/sha512_pad_pkg.sv
verilog/msg_block_buffer.sv
verilog/pad_fsm.sv
verilog/sha512_pad_top.sv
testbench/tb_sha512_pad_top.sv
